/* verilog/iagc_defines.svh */
`ifndef IAGC_DEFINES_SVH
`define IAGC_DEFINES_SVH

`default_nettype none

// sample width for both the reference and the error path.
`define IAGC_DATA_SIZE          16

`define IAGC_ADDR_SIZE          8
`define IAGC_MEM_DEPTH          256   // one word per address.
`define IAGC_ARG_SIZE           8

// settings loaded by reset.
`define IAGC_DEFAULT_MEM_SIZE   32
`define IAGC_DEFAULT_DEC        1

`define IAGC_END_HOLD           4     // cycles the sampler stays in END.

`default_nettype wire

`endif

/* verilog/iagc_pkg.sv */
`default_nettype none

package iagc_pkg;

    // status codes follow the order used by the host software.
    typedef enum logic [3:0] {
        STATUS_RESET     = 4'd0,
        STATUS_INIT      = 4'd1,
        STATUS_IDLE      = 4'd2,
        STATUS_SAMPLE    = 4'd3,
        STATUS_CMD_PARSE = 4'd4,
        STATUS_CMD_READ  = 4'd5,
        STATUS_CMD_ERROR = 4'd6,
        STATUS_DUMP_REF  = 4'd7,
        STATUS_DUMP_ERR  = 4'd8,
        STATUS_CLEAN_MEM = 4'd9,
        STATUS_SET_MEM   = 4'd10,
        STATUS_SET_DEC   = 4'd11,
        STATUS_HALT      = 4'd12
    } iagc_status_e;

    typedef enum logic [1:0] {
        SMP_INIT  = 2'd0,
        SMP_WRITE = 2'd1,
        SMP_END   = 2'd2
    } sampler_state_e;

    typedef enum logic [3:0] {
        OP_SAMPLE    = 4'd1,
        OP_DUMP_REF  = 4'd2,
        OP_DUMP_ERR  = 4'd3,
        OP_CLEAN_MEM = 4'd4,
        OP_SET_MEM   = 4'd5,
        OP_SET_DEC   = 4'd6,
        OP_HALT      = 4'd7,
        OP_READ      = 4'd8
    } cmd_opcode_e;

endpackage

`default_nettype wire

/* verilog/iagc_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

// write path from the sampler into both buffers.
interface sample_bus_if;

    logic [`IAGC_ADDR_SIZE-1:0] addr;
    logic [`IAGC_DATA_SIZE-1:0] ref_data;
    logic [`IAGC_DATA_SIZE-1:0] err_data;
    logic                       write;    // one pair is stored per cycle with write high.

    modport sampler (
        output addr, ref_data, err_data, write
    );

    modport memory (
        input addr, ref_data, err_data, write
    );

endinterface

// readout and clear path between the controller and the memory.
interface mem_ctrl_if;

    logic [`IAGC_ADDR_SIZE-1:0] rd_addr;
    logic                       rd_en;
    logic                       clear;
    logic [`IAGC_DATA_SIZE-1:0] rd_ref;   // valid one cycle after rd_en.
    logic [`IAGC_DATA_SIZE-1:0] rd_err;

    modport controller (
        output rd_addr, rd_en, clear,
        input  rd_ref, rd_err
    );

    modport memory (
        input  rd_addr, rd_en, clear,
        output rd_ref, rd_err
    );

endinterface

`default_nettype wire

/* verilog/iagc_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module iagc_control import iagc_pkg::*; (
    input  wire                          i_clock,
    input  wire                          i_arst_n,
    input  wire                          i_cmd_valid,
    input  wire cmd_opcode_e             i_cmd_opcode,
    input  wire [`IAGC_ARG_SIZE-1:0]     i_cmd_arg,
    input  wire                          i_adc_strobe,
    input  wire                          i_sampler_end,
    output iagc_status_e                 o_status,
    output logic                         o_sample,
    output logic [`IAGC_ADDR_SIZE-1:0]   o_memory_size,
    output logic                         o_busy,
    output logic                         o_cmd_error,
    output logic                         o_sample_done,
    output logic                         o_dump_valid,
    output logic [`IAGC_DATA_SIZE-1:0]   o_dump_data,
    mem_ctrl_if.controller               mem
);

    iagc_status_e               state;
    iagc_status_e               state_nxt;
    cmd_opcode_e                op_q;
    logic [`IAGC_ARG_SIZE-1:0]  arg_q;
    logic [`IAGC_ADDR_SIZE-1:0] memory_size;
    logic [`IAGC_ARG_SIZE-1:0]  dec_factor;
    logic [`IAGC_ARG_SIZE-1:0]  dec_cnt;
    logic [`IAGC_ADDR_SIZE:0]   seq_cnt;      // one bit wider so a full dump can be counted.
    logic                       dump_valid_q;
    logic                       dump_sel_q;
    logic                       end_q;
    logic                       dec_hit;
    logic                       sample_done;
    logic                       is_dump;

    assign is_dump     = (state == STATUS_DUMP_REF) || (state == STATUS_DUMP_ERR);
    assign dec_hit     = dec_cnt == dec_factor - 1'b1;
    // only the rising edge of the sampler end counts. The rest of the END hold is ignored.
    assign sample_done = (state == STATUS_SAMPLE) && i_sampler_end && !end_q;

    always_comb begin
        state_nxt = state;
        case (state)
            STATUS_RESET:     state_nxt = STATUS_INIT;
            STATUS_INIT:      state_nxt = STATUS_IDLE;
            STATUS_IDLE:      if (i_cmd_valid) state_nxt = STATUS_CMD_PARSE;
            STATUS_CMD_PARSE: begin
                case (op_q)
                    OP_SAMPLE:    state_nxt = STATUS_SAMPLE;
                    OP_DUMP_REF:  state_nxt = STATUS_DUMP_REF;
                    OP_DUMP_ERR:  state_nxt = STATUS_DUMP_ERR;
                    OP_CLEAN_MEM: state_nxt = STATUS_CLEAN_MEM;
                    OP_SET_MEM:   state_nxt = (arg_q == '0) ? STATUS_CMD_ERROR : STATUS_SET_MEM;
                    OP_SET_DEC:   state_nxt = (arg_q == '0) ? STATUS_CMD_ERROR : STATUS_SET_DEC;
                    OP_HALT:      state_nxt = STATUS_HALT;
                    OP_READ:      state_nxt = STATUS_CMD_READ;
                    default:      state_nxt = STATUS_CMD_ERROR;
                endcase
            end
            STATUS_SAMPLE:    if (sample_done) state_nxt = STATUS_IDLE;
            // one extra cycle lets the last read word leave while still in the dump state.
            STATUS_DUMP_REF,
            STATUS_DUMP_ERR:  if (seq_cnt == {1'b0, memory_size}) state_nxt = STATUS_IDLE;
            STATUS_CLEAN_MEM: if (seq_cnt[`IAGC_ADDR_SIZE-1:0] == '1) state_nxt = STATUS_IDLE;
            STATUS_HALT:      state_nxt = STATUS_HALT;
            default:          state_nxt = STATUS_IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= STATUS_RESET;
            memory_size  <= `IAGC_ADDR_SIZE'(`IAGC_DEFAULT_MEM_SIZE);
            dec_factor   <= `IAGC_ARG_SIZE'(`IAGC_DEFAULT_DEC);
            dec_cnt      <= '0;
            seq_cnt      <= '0;
            dump_valid_q <= 1'b0;
            dump_sel_q   <= 1'b0;
            end_q        <= 1'b0;
        end else begin
            state        <= state_nxt;
            end_q        <= i_sampler_end;
            dump_valid_q <= mem.rd_en;                       // matches the memory read latency.
            dump_sel_q   <= state == STATUS_DUMP_ERR;
            if (state == STATUS_SET_MEM) memory_size <= arg_q;
            if (state == STATUS_SET_DEC) dec_factor <= arg_q;
            if (state != STATUS_SAMPLE) begin
                dec_cnt <= '0;
            end else if (i_adc_strobe && !i_sampler_end) begin
                dec_cnt <= dec_hit ? '0 : dec_cnt + 1'b1;
            end
            if (is_dump || (state == STATUS_CLEAN_MEM)) seq_cnt <= seq_cnt + 1'b1;
            else seq_cnt <= '0;
        end
    end

    always_ff @(posedge i_clock) begin
        if ((state == STATUS_IDLE) && i_cmd_valid) begin
            op_q  <= i_cmd_opcode;
            arg_q <= i_cmd_arg;
        end
    end

    assign mem.rd_addr = seq_cnt[`IAGC_ADDR_SIZE-1:0];
    assign mem.rd_en   = is_dump && (seq_cnt < {1'b0, memory_size});
    assign mem.clear   = state == STATUS_CLEAN_MEM;

    assign o_status      = state;
    assign o_busy        = state != STATUS_IDLE;
    assign o_cmd_error   = state == STATUS_CMD_ERROR;
    assign o_sample      = (state == STATUS_SAMPLE) && i_adc_strobe && !i_sampler_end && dec_hit;
    assign o_sample_done = sample_done;
    assign o_memory_size = memory_size;
    assign o_dump_valid  = dump_valid_q;
    assign o_dump_data   = dump_sel_q ? mem.rd_err : mem.rd_ref;

endmodule

`default_nettype wire

/* verilog/adc_sampler.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module adc_sampler import iagc_pkg::*; (
    input  wire                          i_clock,
    input  wire                          i_arst_n,
    input  wire iagc_status_e            i_iagc_status,
    input  wire [`IAGC_DATA_SIZE-1:0]    i_reference,
    input  wire [`IAGC_DATA_SIZE-1:0]    i_error,
    input  wire [`IAGC_ADDR_SIZE-1:0]    i_memory_size,
    input  wire                          i_sample,
    output logic                         o_end,
    sample_bus_if.sampler                bus
);

    sampler_state_e             state;
    sampler_state_e             state_nxt;
    logic [`IAGC_ADDR_SIZE-1:0] addr;
    logic [`IAGC_ADDR_SIZE-1:0] addr_nxt;
    logic [`IAGC_DATA_SIZE-1:0] ref_q;
    logic [`IAGC_DATA_SIZE-1:0] err_q;
    logic [3:0]                 end_count;
    logic                       write_q;
    logic                       first_write;
    logic                       accept;
    logic                       last;

    // a pulse arriving in the same cycle as the SAMPLE status is already taken in INIT.
    assign accept   = i_sample && ((state == SMP_WRITE) ||
                      ((state == SMP_INIT) && (i_iagc_status == STATUS_SAMPLE)));
    assign addr_nxt = first_write ? '0 : addr + 1'b1;
    assign last     = addr_nxt == i_memory_size - 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            SMP_INIT: begin
                if (i_iagc_status == STATUS_SAMPLE) begin
                    state_nxt = (accept && last) ? SMP_END : SMP_WRITE;
                end
            end
            SMP_WRITE: if (accept && last) state_nxt = SMP_END;
            SMP_END:   if (end_count == 4'(`IAGC_END_HOLD - 1)) state_nxt = SMP_INIT;
            default:   state_nxt = SMP_INIT;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= SMP_INIT;
            addr        <= '0;
            first_write <= 1'b1;
            write_q     <= 1'b0;
            end_count   <= '0;
        end else if (i_iagc_status == STATUS_RESET) begin
            state       <= SMP_INIT;                        // controller restart.
            addr        <= '0;
            first_write <= 1'b1;
            write_q     <= 1'b0;
            end_count   <= '0;
        end else begin
            state   <= state_nxt;
            write_q <= accept;
            if (accept) begin
                addr        <= addr_nxt;
                first_write <= 1'b0;
            end
            if (state == SMP_END) begin
                // the last write leaves on the first END cycle, before addr clears.
                end_count   <= end_count + 1'b1;
                addr        <= '0;
                first_write <= 1'b1;
            end else begin
                end_count <= '0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            ref_q <= i_reference;
            err_q <= i_error;
        end
    end

    assign bus.addr     = addr;
    assign bus.ref_data = ref_q;
    assign bus.err_data = err_q;
    assign bus.write    = write_q;
    assign o_end        = state == SMP_END;

endmodule

`default_nettype wire

/* verilog/sample_memory.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module sample_memory (
    input  wire            i_clock,
    input  wire            i_arst_n,
    sample_bus_if.memory   wr,
    mem_ctrl_if.memory     ctrl
);

    logic [`IAGC_DATA_SIZE-1:0] ref_mem [`IAGC_MEM_DEPTH];
    logic [`IAGC_DATA_SIZE-1:0] err_mem [`IAGC_MEM_DEPTH];
    logic [`IAGC_DATA_SIZE-1:0] rd_ref_q;
    logic [`IAGC_DATA_SIZE-1:0] rd_err_q;

    // clearing shares the read address and takes priority over a sampler write.
    always_ff @(posedge i_clock) begin
        if (ctrl.clear) begin
            ref_mem[ctrl.rd_addr] <= '0;
            err_mem[ctrl.rd_addr] <= '0;
        end else if (wr.write) begin
            ref_mem[wr.addr] <= wr.ref_data;
            err_mem[wr.addr] <= wr.err_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_ref_q <= '0;
            rd_err_q <= '0;
        end else if (ctrl.rd_en) begin
            rd_ref_q <= ref_mem[ctrl.rd_addr];
            rd_err_q <= err_mem[ctrl.rd_addr];
        end
    end

    assign ctrl.rd_ref = rd_ref_q;   // both words come out together.
    assign ctrl.rd_err = rd_err_q;

endmodule

`default_nettype wire

/* verilog/iagc_capture_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module iagc_capture_top import iagc_pkg::*; (
    input  wire                          i_clock,
    input  wire                          i_arst_n,
    input  wire                          i_cmd_valid,
    input  wire [3:0]                    i_cmd_opcode,
    input  wire [`IAGC_ARG_SIZE-1:0]     i_cmd_arg,
    input  wire                          i_adc_strobe,
    input  wire [`IAGC_DATA_SIZE-1:0]    i_reference,
    input  wire [`IAGC_DATA_SIZE-1:0]    i_error,
    output logic [3:0]                   o_status,
    output logic                         o_busy,
    output logic                         o_cmd_error,
    output logic                         o_sample_done,
    output logic                         o_dump_valid,
    output logic [`IAGC_DATA_SIZE-1:0]   o_dump_data
);

    iagc_status_e               status;
    logic                       sample;
    logic                       sampler_end;
    logic [`IAGC_ADDR_SIZE-1:0] memory_size;

    sample_bus_if u_sample_bus ();
    mem_ctrl_if   u_mem_ctrl ();

    iagc_control u_iagc_control (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_opcode  (cmd_opcode_e'(i_cmd_opcode)),
        .i_cmd_arg     (i_cmd_arg),
        .i_adc_strobe  (i_adc_strobe),
        .i_sampler_end (sampler_end),
        .o_status      (status),
        .o_sample      (sample),
        .o_memory_size (memory_size),
        .o_busy        (o_busy),
        .o_cmd_error   (o_cmd_error),
        .o_sample_done (o_sample_done),
        .o_dump_valid  (o_dump_valid),
        .o_dump_data   (o_dump_data),
        .mem           (u_mem_ctrl.controller)
    );

    adc_sampler u_adc_sampler (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_iagc_status (status),
        .i_reference   (i_reference),
        .i_error       (i_error),
        .i_memory_size (memory_size),
        .i_sample      (sample),
        .o_end         (sampler_end),
        .bus           (u_sample_bus.sampler)
    );

    sample_memory u_sample_memory (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .wr       (u_sample_bus.memory),
        .ctrl     (u_mem_ctrl.memory)
    );

    assign o_status = status;

endmodule

`default_nettype wire

/* tests/iagc_capture_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module iagc_capture_props import iagc_pkg::*; (
    input wire                        i_clock,
    input wire                        i_arst_n,
    input wire iagc_status_e          i_status,
    input wire                        i_busy,
    input wire                        i_cmd_error,
    input wire                        i_dump_valid,
    input wire                        i_write,
    input wire [`IAGC_ADDR_SIZE-1:0]  i_wr_addr,
    input wire [`IAGC_ADDR_SIZE-1:0]  i_memory_size
);

    int fail_count = 0;

    dump_in_dump_state: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_dump_valid |-> (i_status inside {STATUS_DUMP_REF, STATUS_DUMP_ERR}))
        else begin
            $error("dump valid seen outside DUMP_REF and DUMP_ERR");
            fail_count++;
        end

    cmd_error_single: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_cmd_error |=> !i_cmd_error)
        else begin
            $error("command error pulse longer than one cycle");
            fail_count++;
        end

    write_in_range: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_write |-> (i_wr_addr < i_memory_size))
        else begin
            $error("sampler write address beyond the capture length");
            fail_count++;
        end

    // the last sampler write still falls in SAMPLE, so an idle controller sees no write.
    idle_no_write: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_busy |-> !i_write)
        else begin
            $error("sampler write while the controller is idle");
            fail_count++;
        end

endmodule

// the top is where the controller status and the sampler write bus are both visible.
bind iagc_capture_top iagc_capture_props u_iagc_capture_props (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_status      (status),
    .i_busy        (o_busy),
    .i_cmd_error   (o_cmd_error),
    .i_dump_valid  (o_dump_valid),
    .i_write       (u_sample_bus.write),
    .i_wr_addr     (u_sample_bus.addr),
    .i_memory_size (memory_size)
);

`default_nettype wire

/* tests/iagc_capture_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "iagc_defines.svh"

module iagc_capture_tb import iagc_pkg::*;;

    localparam int MAX_CYCLES = 20000;   // the six tests need about 1500 cycles.

    logic        i_clock;
    logic        i_arst_n;
    logic        i_cmd_valid;
    logic [3:0]  i_cmd_opcode;
    logic [7:0]  i_cmd_arg;
    logic        i_adc_strobe;
    logic [15:0] i_reference;
    logic [15:0] i_error;
    wire  [3:0]  o_status;
    wire         o_busy;
    wire         o_cmd_error;
    wire         o_sample_done;
    wire         o_dump_valid;
    wire  [15:0] o_dump_data;

    logic [15:0] ref_model [256];
    logic [15:0] err_model [256];
    logic [15:0] dump_q [$];
    int          seed = 73663;
    int          cycle_count = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cmd_error_count = 0;
    int          sample_done_count = 0;
    int          prop_fails_seen = 0;
    int          busy_cycles;
    int          errors_before;

    iagc_capture_top u_iagc_capture_top (.*);

    always #5 i_clock = ~i_clock;

    // outputs are sampled half a cycle after the DUT updates them.
    always @(negedge i_clock) begin
        if (o_dump_valid === 1'b1) dump_q.push_back(o_dump_data);
        if (o_cmd_error === 1'b1) cmd_error_count++;
        if (o_sample_done === 1'b1) sample_done_count++;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic wait_idle();
        @(negedge i_clock);
        while (o_busy) @(negedge i_clock);
    endtask

    task automatic send_cmd(input logic [3:0] op, input logic [7:0] arg);
        wait_idle();
        @(posedge i_clock);
        i_cmd_valid  <= 1'b1;
        i_cmd_opcode <= op;
        i_cmd_arg    <= arg;
        @(posedge i_clock);
        i_cmd_valid  <= 1'b0;
    endtask

    task automatic set_and_wait(input logic [3:0] op, input logic [7:0] arg);
        send_cmd(op, arg);
        wait_idle();
    endtask

    // every d-th strobe seen in SAMPLE goes to the next model address.
    task automatic run_sample(input int n, input int d);
        int          strobes;
        int          stored;
        int          done_before;
        logic [31:0] rnd;
        strobes = 0;
        stored = 0;
        done_before = sample_done_count;
        send_cmd(OP_SAMPLE, 8'd0);
        @(negedge i_clock);
        while (o_status != STATUS_SAMPLE) @(negedge i_clock);
        while (stored < n) begin
            @(posedge i_clock);
            rnd = $random(seed);
            i_adc_strobe <= rnd[0];
            rnd = $random(seed);
            i_reference <= rnd[31:16];
            i_error     <= rnd[15:0];
            @(negedge i_clock);
            if (i_adc_strobe) begin
                strobes++;
                if (strobes % d == 0) begin
                    ref_model[stored] = i_reference;
                    err_model[stored] = i_error;
                    stored++;
                end
            end
        end
        @(posedge i_clock);
        i_adc_strobe <= 1'b0;
        wait_idle();
        assert (sample_done_count == done_before + 1) else begin
            $display("Fail o_sample_done pulses: got %h, expected %h",
                     sample_done_count - done_before, 1);
            errors++;
        end
    endtask

    task automatic dump_check(input logic use_err, input int n);
        logic [15:0] expected;
        dump_q.delete();
        send_cmd(use_err ? OP_DUMP_ERR : OP_DUMP_REF, 8'd0);
        wait_idle();
        assert (dump_q.size() == n) else begin
            $display("Fail o_dump_valid count: got %h, expected %h", dump_q.size(), n);
            errors++;
        end
        for (int i = 0; i < n && i < dump_q.size(); i++) begin
            expected = use_err ? err_model[i] : ref_model[i];
            assert (dump_q[i] === expected) else begin
                $display("Fail o_dump_data[%0d]: got %h, expected %h", i, dump_q[i], expected);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        int new_fails;
        new_fails = u_iagc_capture_top.u_iagc_capture_props.fail_count - prop_fails_seen;
        prop_fails_seen += new_fails;
        errors += new_fails;
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic apply_reset();
        i_arst_n <= 1'b0;
        repeat (4) @(posedge i_clock);
        i_arst_n <= 1'b1;
    endtask

    initial begin
        i_clock      = 1'b0;
        i_arst_n     = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd_opcode = 4'd0;
        i_cmd_arg    = 8'd0;
        i_adc_strobe = 1'b0;
        i_reference  = 16'd0;
        i_error      = 16'd0;
        @(posedge i_clock);
        apply_reset();
        busy_cycles = 0;
        @(negedge i_clock);
        while (o_busy) begin
            busy_cycles++;
            @(negedge i_clock);
        end
        assert (busy_cycles == 2) else begin
            $display("Fail o_busy cycles after reset: got %h, expected %h", busy_cycles, 2);
            errors++;
        end
        assert (o_status == STATUS_IDLE) else begin
            $display("Fail o_status: got %h, expected %h", o_status, STATUS_IDLE);
            errors++;
        end
        assert (cmd_error_count + sample_done_count + dump_q.size() == 0) else begin
            $display("a pulse or dump valid was seen right after reset");
            errors++;
        end
        end_test("reset");

        run_sample(`IAGC_DEFAULT_MEM_SIZE, `IAGC_DEFAULT_DEC);
        dump_check(1'b0, `IAGC_DEFAULT_MEM_SIZE);
        dump_check(1'b1, `IAGC_DEFAULT_MEM_SIZE);
        end_test("default capture");

        set_and_wait(OP_SET_MEM, 8'd10);
        set_and_wait(OP_SET_DEC, 8'd3);
        run_sample(10, 3);
        dump_check(1'b0, 10);
        dump_check(1'b1, 10);
        end_test("length 10 decimation 3");

        set_and_wait(OP_CLEAN_MEM, 8'd0);
        for (int i = 0; i < 256; i++) begin
            ref_model[i] = 16'd0;
            err_model[i] = 16'd0;
        end
        dump_check(1'b0, 10);
        end_test("clean memory");

        errors_before = cmd_error_count;
        set_and_wait(4'hf, 8'd0);
        set_and_wait(OP_SET_MEM, 8'd0);
        set_and_wait(OP_SET_DEC, 8'd0);
        assert (cmd_error_count == errors_before + 3) else begin
            $display("Fail o_cmd_error pulses: got %h, expected %h",
                     cmd_error_count - errors_before, 3);
            errors++;
        end
        dump_check(1'b0, 10);
        end_test("command errors");

        send_cmd(OP_HALT, 8'd0);
        repeat (2) @(negedge i_clock);
        @(posedge i_clock);
        i_cmd_valid  <= 1'b1;
        i_cmd_opcode <= OP_SET_MEM;
        i_cmd_arg    <= 8'd5;
        repeat (16) begin
            @(negedge i_clock);
            assert (o_busy && o_status == STATUS_HALT) else begin
                $display("Fail o_status in HALT: got %h, expected %h", o_status, STATUS_HALT);
                errors++;
            end
        end
        @(posedge i_clock);
        i_cmd_valid <= 1'b0;
        apply_reset();
        dump_check(1'b0, `IAGC_DEFAULT_MEM_SIZE);
        end_test("halt and reset");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/iagc_pkg.sv
verilog/iagc_if.sv
verilog/iagc_control.sv
verilog/adc_sampler.sv
verilog/sample_memory.sv
verilog/iagc_capture_top.sv
tests/iagc_capture_props.sv
tests/iagc_capture_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module iagc_capture_tb \
        -f list.f --Mdir obj_dir -o iagc_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/iagc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
